/* tb/cart_testdata.txt */
# T name | W reg_addr data | I cycles | A src addr write wdata expect value (hex)
# src 0 CPU 1 PPU, expect M request at address value, C nametable a10 value, N no output
T menu_after_reset
I 10
A 0 8000 0 00 M 7D0000
A 0 9234 0 00 M 7D1234
A 0 FFFC 0 00 M 7D7FFC
A 1 0100 0 00 M 7D8100
A 1 1FFF 0 00 M 7D9FFF
A 0 6010 0 00 M 7E0010
A 1 2400 0 00 C 0
A 1 2800 0 00 C 1
T nrom_switch
W 0 5E1
W 1 001
A 0 FFFC 0 00 M 007FFC
A 0 8123 0 00 M 000123
A 1 1ABC 0 00 M 009ABC
A 1 2400 0 00 C 1
A 1 2800 0 00 C 0
W 0 1C1
A 0 C456 0 00 M 000456
A 1 0100 0 00 M 004100
A 1 2800 0 00 C 1
T bank_switching
W 0 A22
W 1 001
A 0 FFFC 0 00 M 01FFFC
A 0 8010 0 00 M 000010
A 0 8000 1 05 N 0
A 0 8010 0 00 M 014010
A 0 C000 0 00 M 01C000
A 1 0010 0 00 M 020010
W 0 5E3
W 1 001
A 0 FFFC 0 00 M 007FFC
A 1 0123 0 00 M 008123
A 0 8000 1 02 N 0
A 1 0123 0 00 M 00C123
W 0 A44
W 1 001
A 0 FFFC 0 00 M 007FFC
A 1 2000 0 00 C 0
A 0 8000 1 13 N 0
A 0 E000 0 00 M 01E000
A 1 2000 0 00 C 1
T wram_and_chr_ram
A 0 6000 0 00 M 7E0000
A 0 7FFF 1 A5 M 7E1FFF
A 1 0040 1 77 M 040040
W 0 244
A 1 0040 1 77 N 0
A 1 0040 0 00 M 040040
A 1 3F00 0 00 N 0
T credit_backpressure
A 0 6000 0 00 M 7E0000
A 0 6001 0 00 M 7E0001
A 0 6002 1 11 M 7E0002
A 1 2000 0 00 C 1
A 0 6003 0 00 M 7E0003
A 0 8000 0 00 M 018000
A 1 0100 0 00 M 040100
A 0 6004 1 22 M 7E0004
A 1 2400 0 00 C 1
A 0 6005 0 00 M 7E0005
A 0 6006 0 00 M 7E0006
A 0 FFFC 0 00 M 01FFFC

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cartridge mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f src.f \
    --top-module tb_cart_mapper -o tb_cart_mapper
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_cart_mapper > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0

/* src.f */
+incdir+include
hdl/cart_pkg.sv
hdl/cart_reg_file.sv
hdl/mapper_bank.sv
hdl/sdram_place.sv
hdl/mem_issue.sv
hdl/cart_mapper_top.sv
tb/tb_cart_mapper.sv

/* tb/tb_cart_mapper.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module tb_cart_mapper import cart_pkg::*; ();

    typedef struct packed {
        logic                       is_mem;
        logic [`CART_ADDR_BITS-1:0] value;
        logic                       write;
        logic [7:0]                 wdata;
    } expect_t;

    logic                       clk = 1'b0;
    logic                       cpu_reset;
    logic                       reg_valid;
    logic [3:0]                 reg_addr;
    host_reg_u                  reg_data;
    logic                       acc_valid;
    access_src_t                acc_src;
    logic [15:0]                acc_addr;
    logic                       acc_write;
    logic [7:0]                 acc_wdata;
    logic                       acc_ready;
    logic                       mem_req_valid;
    logic [`CART_ADDR_BITS-1:0] mem_req_addr;
    logic                       mem_req_write;
    logic [7:0]                 mem_req_wdata;
    logic                       mem_credit = 1'b0;
    logic                       ciram_valid;
    logic                       ciram_a10;

    expect_t     exp_q[$];
    int unsigned due_q[$];
    int unsigned cycle = 0;
    int unsigned cycle_limit = 1000;
    int unsigned last_due = 0;
    int          outstanding = 0;
    int          errors = 0;
    int          checks = 0;

    always #50 clk = ~clk;

    cart_mapper_top i_dut (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .reg_valid(reg_valid),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .acc_valid(acc_valid),
        .acc_src(acc_src),
        .acc_addr(acc_addr),
        .acc_write(acc_write),
        .acc_wdata(acc_wdata),
        .acc_ready(acc_ready),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .mem_req_write(mem_req_write),
        .mem_req_wdata(mem_req_wdata),
        .mem_credit(mem_credit),
        .ciram_valid(ciram_valid),
        .ciram_a10(ciram_a10)
    );

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic match_output();
        expect_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t: output appeared while none was expected", $time);
        end else begin
            e = exp_q.pop_front();
            compare_value("mem_req_valid", 32'(e.is_mem), 32'(mem_req_valid));
            if (e.is_mem && mem_req_valid) begin
                compare_value("mem_req_addr", 32'(e.value), 32'(mem_req_addr));
                compare_value("mem_req_write", 32'(e.write), 32'(mem_req_write));
                if (e.write) begin
                    compare_value("mem_req_wdata", 32'(e.wdata), 32'(mem_req_wdata));
                end
            end else if (!e.is_mem && ciram_valid) begin
                compare_value("ciram_a10", 32'(e.value[0]), 32'(ciram_a10));
            end
        end
    endtask

    // Returns stay in order with at most one per cycle
    task automatic schedule_credit();
        int unsigned due;
        due = cycle + 1 + ($urandom % 6);
        if (due <= last_due) begin
            due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // Memory model
    always @(posedge clk) begin
        #1;
        if (due_q.size() != 0 && due_q[0] <= cycle) begin
            mem_credit = 1'b1;
            void'(due_q.pop_front());
        end else begin
            mem_credit = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!cpu_reset) begin
            if (mem_req_valid || ciram_valid) begin
                match_output();
            end
            if (mem_req_valid) begin
                outstanding++;
                if (outstanding > `CART_CREDIT_MAX) begin
                    errors++;
                    $display("Error at %0t: %0d requests outstanding, above the credit limit",
                             $time, outstanding);
                end
                schedule_credit();
            end
            if (mem_credit) begin
                outstanding--;
            end
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [11:0] data);
        reg_valid = 1'b1;
        reg_addr = addr;
        reg_data = host_reg_u'(data);
        @(posedge clk);
        #1;
        reg_valid = 1'b0;
    endtask

    task automatic do_access(input logic src, input logic [15:0] addr, input logic wr,
                             input logic [7:0] wd, input string kind, input logic [31:0] value);
        logic    ready;
        expect_t e;
        if (kind == "M" || kind == "C") begin
            e.is_mem = kind == "M";
            e.value = value[`CART_ADDR_BITS-1:0];
            e.write = wr;
            e.wdata = wd;
            exp_q.push_back(e);
        end
        acc_valid = 1'b1;
        acc_src = access_src_t'(src);
        acc_addr = addr;
        acc_write = wr;
        acc_wdata = wd;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            ready = acc_ready;
            @(posedge clk);
        end
        #1;
        acc_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic finish_test(input string name, input int err_start);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        $display("Finished test %s: %0d errors", name, errors - err_start);
    endtask

    initial begin
        int          fd;
        int          code;
        int          nlines;
        int          err_start;
        int          tests;
        bit          test_open;
        string       op;
        string       name;
        string       cur_name;
        string       line;
        string       kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;

        cpu_reset = 1'b1;
        reg_valid = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        acc_valid = 1'b0;
        acc_src = SRC_CPU;
        acc_addr = '0;
        acc_write = 1'b0;
        acc_wdata = '0;
        void'($urandom(32'hc320));
        nlines = 0;
        tests = 0;
        err_start = 0;
        test_open = 1'b0;

        // Run length follows the size of the vector file
        fd = $fopen("tb/cart_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tb/cart_testdata.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                nlines++;
            end
            $fclose(fd);
            cycle_limit = 20 * nlines + 100;
        end

        repeat (16) @(posedge clk);
        #1;
        cpu_reset = 1'b0;
        compare_value("acc_ready", 32'd1, 32'(acc_ready));
        compare_value("mem_req_valid", 32'd0, 32'(mem_req_valid));
        compare_value("ciram_valid", 32'd0, 32'(ciram_valid));

        if (fd != 0) begin
            fd = $fopen("tb/cart_testdata.txt", "r");
            code = $fscanf(fd, "%s", op);
            while (code == 1) begin
                if (op.substr(0, 0) == "#") begin
                    code = $fgets(line, fd);
                end else if (op == "T") begin
                    code = $fscanf(fd, "%s", name);
                    if (test_open) begin
                        finish_test(cur_name, err_start);
                    end
                    cur_name = name;
                    err_start = errors;
                    test_open = 1'b1;
                    tests++;
                end else if (op == "W") begin
                    code = $fscanf(fd, "%h %h", f1, f2);
                    write_reg(f1[3:0], f2[11:0]);
                end else if (op == "I") begin
                    code = $fscanf(fd, "%d", f1);
                    idle(int'(f1));
                end else if (op == "A") begin
                    code = $fscanf(fd, "%h %h %h %h %s %h", f1, f2, f3, f4, kind, f5);
                    do_access(f1[0], f2[15:0], f3[0], f4[7:0], kind, f5);
                end else begin
                    errors++;
                    $display("Unknown record '%s' in the test data", op);
                end
                code = $fscanf(fd, "%s", op);
            end
            if (test_open) begin
                finish_test(cur_name, err_start);
            end
            $fclose(fd);
        end

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && tests > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cart_mapper_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module cart_mapper_top import cart_pkg::*; (
    input  logic                       clk,
    input  logic                       cpu_reset,

    // Host register port
    input  logic                       reg_valid,
    input  logic [3:0]                 reg_addr,
    input  host_reg_u                  reg_data,

    // Console bus accesses
    input  logic                       acc_valid,
    input  access_src_t                acc_src,
    input  logic [15:0]                acc_addr,
    input  logic                       acc_write,
    input  logic [7:0]                 acc_wdata,
    output logic                       acc_ready,

    // SDRAM requests
    output logic                       mem_req_valid,
    output logic [`CART_ADDR_BITS-1:0] mem_req_addr,
    output logic                       mem_req_write,
    output logic [7:0]                 mem_req_wdata,
    input  logic                       mem_credit,

    // CIRAM nametable select
    output logic                       ciram_valid,
    output logic                       ciram_a10
);

    mapper_id_t select;
    logic [4:0] size_log2;
    logic       mirroring;
    logic       chr_ram;
    logic       vector_fetch;
    logic       advance;

    logic                       t_valid;
    acc_kind_t                  t_kind;
    logic [`CART_ADDR_BITS-1:0] t_offset;
    logic                       t_write;
    logic [7:0]                 t_wdata;
    logic                       t_ciram_a10;

    logic                       p_valid;
    logic                       p_is_mem;
    logic [`CART_ADDR_BITS-1:0] p_addr;
    logic                       p_write;
    logic [7:0]                 p_wdata;
    logic                       p_ciram_a10;

    assign acc_ready = advance;

    cart_reg_file i_reg_file (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .reg_valid(reg_valid),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .vector_fetch(vector_fetch),
        .select(select),
        .size_log2(size_log2),
        .mirroring(mirroring),
        .chr_ram(chr_ram)
    );

    mapper_bank i_mapper_bank (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .advance(advance),
        .acc_valid(acc_valid),
        .acc_src(acc_src),
        .acc_addr(acc_addr),
        .acc_write(acc_write),
        .acc_wdata(acc_wdata),
        .select(select),
        .mirroring(mirroring),
        .chr_ram(chr_ram),
        .vector_fetch(vector_fetch),
        .t_valid(t_valid),
        .t_kind(t_kind),
        .t_offset(t_offset),
        .t_write(t_write),
        .t_wdata(t_wdata),
        .t_ciram_a10(t_ciram_a10)
    );

    sdram_place i_sdram_place (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .advance(advance),
        .t_valid(t_valid),
        .t_kind(t_kind),
        .t_offset(t_offset),
        .t_write(t_write),
        .t_wdata(t_wdata),
        .t_ciram_a10(t_ciram_a10),
        .select(select),
        .size_log2(size_log2),
        .p_valid(p_valid),
        .p_is_mem(p_is_mem),
        .p_addr(p_addr),
        .p_write(p_write),
        .p_wdata(p_wdata),
        .p_ciram_a10(p_ciram_a10)
    );

    mem_issue i_mem_issue (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .p_valid(p_valid),
        .p_is_mem(p_is_mem),
        .p_addr(p_addr),
        .p_write(p_write),
        .p_wdata(p_wdata),
        .p_ciram_a10(p_ciram_a10),
        .mem_credit(mem_credit),
        .advance(advance),
        .mem_req_valid(mem_req_valid),
        .mem_req_addr(mem_req_addr),
        .mem_req_write(mem_req_write),
        .mem_req_wdata(mem_req_wdata),
        .ciram_valid(ciram_valid),
        .ciram_a10(ciram_a10)
    );

endmodule

`default_nettype wire

/* hdl/mem_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module mem_issue (
    input  logic                       clk,
    input  logic                       cpu_reset,
    input  logic                       p_valid,
    input  logic                       p_is_mem,
    input  logic [`CART_ADDR_BITS-1:0] p_addr,
    input  logic                       p_write,
    input  logic [7:0]                 p_wdata,
    input  logic                       p_ciram_a10,
    input  logic                       mem_credit,
    output logic                       advance,
    output logic                       mem_req_valid,
    output logic [`CART_ADDR_BITS-1:0] mem_req_addr,
    output logic                       mem_req_write,
    output logic [7:0]                 mem_req_wdata,
    output logic                       ciram_valid,
    output logic                       ciram_a10
);

    localparam int CW = `CART_CREDIT_BITS;

    logic [CW-1:0] credits;
    logic          mem_item;
    logic          issue;

    assign mem_item = p_valid && p_is_mem;
    assign issue = mem_item && credits != '0;

    // Whole pipeline freezes while a memory item has no credit
    assign advance = !mem_item || issue;

    assign mem_req_valid = issue;
    assign mem_req_addr  = p_addr;
    assign mem_req_write = p_write;
    assign mem_req_wdata = p_wdata;

    // Nametable selects go straight to CIRAM
    assign ciram_valid = p_valid && !p_is_mem;
    assign ciram_a10   = p_ciram_a10;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            credits <= CW'(`CART_CREDIT_MAX);
        end else begin
            credits <= credits + CW'(mem_credit) - CW'(issue);
        end
    end

endmodule

`default_nettype wire

/* hdl/sdram_place.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module sdram_place import cart_pkg::*; (
    input  logic                       clk,
    input  logic                       cpu_reset,
    input  logic                       advance,
    input  logic                       t_valid,
    input  acc_kind_t                  t_kind,
    input  logic [`CART_ADDR_BITS-1:0] t_offset,
    input  logic                       t_write,
    input  logic [7:0]                 t_wdata,
    input  logic                       t_ciram_a10,
    input  mapper_id_t                 select,
    input  logic [4:0]                 size_log2,
    output logic                       p_valid,
    output logic                       p_is_mem,
    output logic [`CART_ADDR_BITS-1:0] p_addr,
    output logic                       p_write,
    output logic [7:0]                 p_wdata,
    output logic                       p_ciram_a10
);

    localparam int AW = `CART_ADDR_BITS;

    // Configuration seen when the translate stage took its item
    mapper_id_t    t_select;
    logic [4:0]    t_size;
    logic          menu;
    logic [AW-1:0] prg_mask;
    logic [AW-1:0] chr_bit;
    logic [AW-1:0] addr;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            t_select <= MAP_MENU;
            t_size   <= '0;
        end else if (advance) begin
            t_select <= select;
            t_size   <= size_log2;
        end
    end

    assign menu = t_select == MAP_MENU;
    assign prg_mask = ~({AW{1'b1}} << t_size);
    // CHR image sits right above PRG
    assign chr_bit = AW'(1) << t_size;

    always_comb begin
        case (t_kind)
            KIND_PRG:  addr = menu ? (t_offset | `CART_MENU_PRG_BASE) : (t_offset & prg_mask);
            KIND_CHR:  addr = menu ? (t_offset | `CART_MENU_CHR_BASE) : (t_offset | chr_bit);
            KIND_WRAM: addr = `CART_WRAM_BASE | AW'(t_offset[12:0]);
            default:   addr = t_offset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            p_valid <= 1'b0;
        end else if (advance) begin
            p_valid <= t_valid && t_kind != KIND_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            p_is_mem    <= t_kind != KIND_NT;
            p_addr      <= addr;
            p_write     <= t_write;
            p_wdata     <= t_wdata;
            p_ciram_a10 <= t_ciram_a10;
        end
    end

endmodule

`default_nettype wire

/* hdl/mapper_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module mapper_bank import cart_pkg::*; (
    input  logic                       clk,
    input  logic                       cpu_reset,
    input  logic                       advance,
    input  logic                       acc_valid,
    input  access_src_t                acc_src,
    input  logic [15:0]                acc_addr,
    input  logic                       acc_write,
    input  logic [7:0]                 acc_wdata,
    input  mapper_id_t                 select,
    input  logic                       mirroring,
    input  logic                       chr_ram,
    output logic                       vector_fetch,
    output logic                       t_valid,
    output acc_kind_t                  t_kind,
    output logic [`CART_ADDR_BITS-1:0] t_offset,
    output logic                       t_write,
    output logic [7:0]                 t_wdata,
    output logic                       t_ciram_a10
);

    localparam int AW = `CART_ADDR_BITS;

    logic [3:0]  ux_bank;
    logic [1:0]  cn_bank;
    logic [2:0]  ax_bank;
    logic        ax_screen;
    logic        take;
    logic        bank_write;
    logic [13:0] ppu_addr;
    acc_kind_t   kind;
    logic [AW-1:0] offset;
    logic        a10;

    assign take = acc_valid && advance;
    assign ppu_addr = acc_addr[13:0];

    assign vector_fetch = take && acc_src == SRC_CPU && !acc_write
                          && acc_addr == 16'hFFFC;
    assign bank_write = take && acc_src == SRC_CPU && acc_write && acc_addr[15];

    // Bank registers of the running mapper
    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            ux_bank   <= '0;
            cn_bank   <= '0;
            ax_bank   <= '0;
            ax_screen <= 1'b0;
        end else if (bank_write) begin
            case (select)
                MAP_UXROM: ux_bank <= acc_wdata[3:0];
                MAP_CNROM: cn_bank <= acc_wdata[1:0];
                MAP_AXROM: begin
                    ax_bank   <= acc_wdata[2:0];
                    ax_screen <= acc_wdata[4];
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        kind = KIND_NONE;
        offset = '0;

        // Vertical mirroring follows A10, horizontal follows A11
        if (select == MAP_AXROM) begin
            a10 = ax_screen;
        end else begin
            a10 = mirroring ? ppu_addr[10] : ppu_addr[11];
        end

        if (acc_src == SRC_CPU) begin
            if (acc_addr[15:13] == 3'b011) begin
                kind = KIND_WRAM;
                offset = AW'(acc_addr[12:0]);
            end else if (acc_addr[15] && !acc_write) begin
                kind = KIND_PRG;
                case (select)
                    MAP_UXROM: begin
                        // Upper half is fixed to the last bank
                        if (acc_addr[14]) begin
                            offset = AW'({4'hF, acc_addr[13:0]});
                        end else begin
                            offset = AW'({ux_bank, acc_addr[13:0]});
                        end
                    end
                    MAP_AXROM: offset = AW'({ax_bank, acc_addr[14:0]});
                    default:   offset = AW'(acc_addr[14:0]);
                endcase
            end
        end else if (!ppu_addr[13]) begin
            // Pattern writes only reach CHR RAM
            if (!acc_write || chr_ram) begin
                kind = KIND_CHR;
                if (select == MAP_CNROM) begin
                    offset = AW'({cn_bank, ppu_addr[12:0]});
                end else begin
                    offset = AW'(ppu_addr[12:0]);
                end
            end
        end else if (ppu_addr[13:8] != 6'h3F) begin
            kind = KIND_NT;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            t_valid <= 1'b0;
        end else if (advance) begin
            t_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            t_kind      <= kind;
            t_offset    <= offset;
            t_write     <= acc_write;
            t_wdata     <= acc_wdata;
            t_ciram_a10 <= a10;
        end
    end

endmodule

`default_nettype wire

/* hdl/cart_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module cart_reg_file import cart_pkg::*; (
    input  logic       clk,
    input  logic       cpu_reset,
    input  logic       reg_valid,
    input  logic [3:0] reg_addr,
    input  host_reg_u  reg_data,
    input  logic       vector_fetch,
    output mapper_id_t select,
    output logic [4:0] size_log2,
    output logic       mirroring,
    output logic       chr_ram
);

    mapper_id_t active_sel;
    mapper_id_t pending_sel;
    logic       armed;
    logic       switch_now;

    // Unknown mapper numbers run as NROM
    function automatic mapper_id_t decode_select(input logic [4:0] raw);
        mapper_id_t id;
        if (raw < 5'(`CART_MAPPER_CNT)) begin
            id = mapper_id_t'(raw);
        end else begin
            id = MAP_NROM;
        end
        return id;
    endfunction

    // Switch happens in the very cycle the reset vector is fetched
    assign switch_now = armed && vector_fetch;
    assign select = switch_now ? pending_sel : active_sel;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            active_sel  <= MAP_MENU;
            pending_sel <= MAP_MENU;
            armed       <= 1'b0;
            size_log2   <= '0;
            mirroring   <= 1'b0;
            chr_ram     <= 1'b0;
        end else begin
            if (switch_now) begin
                active_sel <= pending_sel;
                armed      <= 1'b0;
            end

            if (reg_valid) begin
                case (reg_addr)
                    REG_MAPPER: begin
                        pending_sel <= decode_select(reg_data.cfg.select);
                        size_log2   <= reg_data.cfg.size_log2;
                        mirroring   <= reg_data.cfg.mirroring;
                        chr_ram     <= reg_data.cfg.chr_ram;
                    end
                    REG_SWITCH: begin
                        // The reset vector fetch disarms it again
                        if (reg_data.sw.start_app) begin
                            armed <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cart_pkg.sv */
`default_nettype none

package cart_pkg;

    typedef enum logic {
        SRC_CPU = 1'b0,
        SRC_PPU = 1'b1
    } access_src_t;

    typedef enum logic [4:0] {
        MAP_MENU  = 5'd0,
        MAP_NROM  = 5'd1,
        MAP_UXROM = 5'd2,
        MAP_CNROM = 5'd3,
        MAP_AXROM = 5'd4
    } mapper_id_t;

    // What a bus access turns into after banking
    typedef enum logic [2:0] {
        KIND_NONE = 3'd0,
        KIND_PRG  = 3'd1,
        KIND_WRAM = 3'd2,
        KIND_CHR  = 3'd3,
        KIND_NT   = 3'd4
    } acc_kind_t;

    typedef struct packed {
        logic       chr_ram;
        logic       mirroring;  // 1 = vertical
        logic [4:0] size_log2;
        logic [4:0] select;
    } mapper_cfg_t;

    typedef struct packed {
        logic [10:0] reserved;
        logic        start_app;
    } switch_ctrl_t;

    // Host register word decoded by register address
    typedef union packed {
        mapper_cfg_t  cfg;
        switch_ctrl_t sw;
    } host_reg_u;

    localparam logic [3:0] REG_MAPPER = 4'd0;
    localparam logic [3:0] REG_SWITCH = 4'd1;

endpackage

`default_nettype wire

/* include/cart_config.svh */
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// SDRAM word address width
`define CART_ADDR_BITS 23

// Mapper indices from this count on fall back to NROM
`define CART_MAPPER_CNT 5

// Fixed SDRAM regions
// Menu PRG   7D0000  32KB
// Menu CHR   7D8000  32KB
// Work RAM   7E0000  128KB
`define CART_MENU_PRG_BASE 23'h7D0000
`define CART_MENU_CHR_BASE 23'h7D8000
`define CART_WRAM_BASE 23'h7E0000

// Request credits granted by the memory side after reset
`define CART_CREDIT_MAX 4

// Counter width that holds CART_CREDIT_MAX
`define CART_CREDIT_BITS 3

`endif
